/* hw/buf_addr_pkg.sv */
package buf_addr_pkg;

	// word index width inside one segment, 16 words
	localparam int seg_size_w = 4;
	// segment address width, 64 segments in the buffer
	localparam int buf_seg_aw = 6;
	// full word address into the buffer
	localparam int buf_aw = buf_seg_aw + seg_size_w;
	// descriptor adds the final-segment flag on top
	localparam int desc_w = buf_aw + 1;

	// segment number inside the buffer
	typedef logic [buf_seg_aw-1:0] seg_addr_t;
	// word position inside a segment
	typedef logic [seg_size_w-1:0] word_idx_t;
	// buffer read address, segment then word
	typedef logic [buf_aw-1:0] buf_addr_t;
	// {final flag, last word index, segment address}
	typedef logic [desc_w-1:0] ptr_desc_t;

endpackage

/* hw/flow_sched_pkg.sv */
package flow_sched_pkg;

	// flow number width
	localparam int flows_w = 3;
	// number of flows served
	localparam int num_flows = 2 ** flows_w;
	// per-flow queue address width, 16 descriptors deep
	localparam int fifo_aw = 4;

	// flow number
	typedef logic [flows_w-1:0] flow_id_t;
	// one bit per flow
	typedef logic [num_flows-1:0] flow_mask_t;

	// segment reader states
	typedef enum logic [1:0] {
		rd_idle,
		rd_load,
		rd_stream,
		rd_starve
	} rd_state_t;

endpackage

/* hw/seg_ptr_fifo.sv */
module seg_ptr_fifo (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   push,
	input  buf_addr_pkg::ptr_desc_t push_desc,
	input  logic                   pop,
	output buf_addr_pkg::ptr_desc_t head,
	output logic                   empty
);
	import buf_addr_pkg::*;
	import flow_sched_pkg::*;

	// descriptor storage
	ptr_desc_t mem [2**fifo_aw];
	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	// one extra bit so full is distinct from empty
	logic [fifo_aw:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = count[fifo_aw];
	assign empty = (count == '0);
	// drop writes when full, reads when empty
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// oldest entry, fall-through
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_desc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* hw/flow_ptr_queues.sv */
module flow_ptr_queues (
	input  logic                      clk,
	input  logic                      rstn,
	input  buf_addr_pkg::ptr_desc_t   used_pointer,
	input  logic                      used_pointer_valid,
	input  flow_sched_pkg::flow_id_t  used_pointer_flow,
	input  flow_sched_pkg::flow_id_t  cur_flow,
	input  logic                      pop,
	output flow_sched_pkg::flow_mask_t flow_empty,
	output buf_addr_pkg::ptr_desc_t   head_desc,
	output logic                      head_empty
);
	import buf_addr_pkg::*;
	import flow_sched_pkg::*;

	// head of every queue, muxed by cur_flow below
	ptr_desc_t heads [num_flows];

	for (genvar g = 0; g < num_flows; g++) begin : gen_flow_q
		logic q_push;
		logic q_pop;

		// write only the queue named by the tag
		assign q_push = used_pointer_valid && (used_pointer_flow == flow_id_t'(g));
		// reader only ever pops its own flow
		assign q_pop = pop && (cur_flow == flow_id_t'(g));

		seg_ptr_fifo seg_ptr_fifo_i (
			.clk       (clk),
			.rstn      (rstn),
			.push      (q_push),
			.push_desc (used_pointer),
			.pop       (q_pop),
			.head      (heads[g]),
			.empty     (flow_empty[g])
		);
	end

	// status of the flow being read
	assign head_desc = heads[cur_flow];
	assign head_empty = flow_empty[cur_flow];

endmodule

/* hw/rr_flow_arbiter.sv */
module rr_flow_arbiter (
	input  logic                       clk,
	input  logic                       rstn,
	input  flow_sched_pkg::flow_mask_t flow_empty,
	input  logic                       arb_idle,
	output logic                       grant,
	output flow_sched_pkg::flow_id_t   grant_flow
);
	import flow_sched_pkg::*;

	// next flow to look at
	flow_id_t scan_ptr;
	logic scan_en;
	logic scan_hit;

	// only scan while the reader waits and nothing is in flight
	assign scan_en = arb_idle && !grant;
	assign scan_hit = !flow_empty[scan_ptr];

	// granted flow number, held until the next grant
	always_ff @(posedge clk) begin
		if (scan_en && scan_hit) begin
			grant_flow <= scan_ptr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			grant <= 1'b0;
			scan_ptr <= '0;
		end else begin
			// grant is a single-cycle pulse
			grant <= 1'b0;
			if (scan_en) begin
				if (scan_hit) begin
					grant <= 1'b1;
				end
				// on a hit this is grant_flow + 1, so the scan
				// resumes past the flow that was just served
				// wraps at num_flows
				scan_ptr <= scan_ptr + 1'b1;
			end
		end
	end

endmodule

/* hw/segment_reader.sv */
module segment_reader (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      grant,
	input  flow_sched_pkg::flow_id_t  grant_flow,
	input  buf_addr_pkg::ptr_desc_t   head_desc,
	input  logic                      head_empty,
	output flow_sched_pkg::flow_id_t  cur_flow,
	output logic                      pop,
	output logic                      arb_idle,
	output buf_addr_pkg::buf_addr_t   b_raddr,
	output logic                      s_rvalid,
	output buf_addr_pkg::seg_addr_t   freed_pointer,
	output logic                      freed_pointer_valid
);
	import buf_addr_pkg::*;
	import flow_sched_pkg::*;

	rd_state_t state;
	// descriptor of the segment being streamed
	ptr_desc_t cur_desc;
	word_idx_t word_cnt;

	// descriptor fields
	seg_addr_t cur_seg;
	word_idx_t last_idx;
	logic final_seg;
	logic seg_end;

	assign cur_seg = cur_desc[buf_seg_aw-1:0];
	assign last_idx = cur_desc[buf_aw-1:buf_seg_aw];
	assign final_seg = cur_desc[desc_w-1];
	// this cycle carries the segment's last word
	assign seg_end = (word_cnt == last_idx);

	// arbiter only runs between packets
	assign arb_idle = (state == rd_idle);
	// head leaves the queue as it is captured
	assign pop = (state == rd_load);
	// one word per stream cycle
	assign s_rvalid = (state == rd_stream);
	assign b_raddr = {cur_seg, word_cnt};

	// capture the head while in load
	always_ff @(posedge clk) begin
		if (state == rd_load) begin
			cur_desc <= head_desc;
		end
	end

	// freed address, valid with the strobe
	always_ff @(posedge clk) begin
		if (state == rd_stream && seg_end) begin
			freed_pointer <= cur_seg;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= rd_idle;
			cur_flow <= '0;
			word_cnt <= '0;
			freed_pointer_valid <= 1'b0;
		end else begin
			freed_pointer_valid <= 1'b0;
			case (state)
				rd_idle: begin
					// lock onto the granted flow
					if (grant) begin
						cur_flow <= grant_flow;
						state <= rd_load;
					end
				end
				rd_load: begin
					word_cnt <= '0;
					state <= rd_stream;
				end
				rd_stream: begin
					if (seg_end) begin
						// hand the segment back next cycle
						freed_pointer_valid <= 1'b1;
						if (final_seg) begin
							state <= rd_idle;
						end else if (!head_empty) begin
							state <= rd_load;
						end else begin
							// packet continues but its next
							// descriptor is not written yet
							state <= rd_starve;
						end
					end else begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
				rd_starve: begin
					// stay on this flow until more arrives
					if (!head_empty) begin
						state <= rd_load;
					end
				end
				default: begin
					state <= rd_idle;
				end
			endcase
		end
	end

endmodule

/* hw/buffer_read_sched.sv */
module buffer_read_sched (
	input  logic                     clk,
	input  logic                     rstn,
	input  buf_addr_pkg::ptr_desc_t  used_pointer,
	input  logic                     used_pointer_valid,
	input  flow_sched_pkg::flow_id_t used_pointer_flow,
	output buf_addr_pkg::buf_addr_t  b_raddr,
	output logic                     s_rvalid,
	output buf_addr_pkg::seg_addr_t  freed_pointer,
	output logic                     freed_pointer_valid
);
	import buf_addr_pkg::*;
	import flow_sched_pkg::*;

	// queues to arbiter
	flow_mask_t flow_empty;
	// queues to reader, for the selected flow
	ptr_desc_t head_desc;
	logic head_empty;
	// reader back to queues
	flow_id_t cur_flow;
	logic pop;
	// reader and arbiter handshake
	logic arb_idle;
	logic grant;
	flow_id_t grant_flow;

	flow_ptr_queues flow_ptr_queues_i (
		.clk                (clk),
		.rstn               (rstn),
		.used_pointer       (used_pointer),
		.used_pointer_valid (used_pointer_valid),
		.used_pointer_flow  (used_pointer_flow),
		.cur_flow           (cur_flow),
		.pop                (pop),
		.flow_empty         (flow_empty),
		.head_desc          (head_desc),
		.head_empty         (head_empty)
	);

	rr_flow_arbiter rr_flow_arbiter_i (
		.clk        (clk),
		.rstn       (rstn),
		.flow_empty (flow_empty),
		.arb_idle   (arb_idle),
		.grant      (grant),
		.grant_flow (grant_flow)
	);

	segment_reader segment_reader_i (
		.clk                 (clk),
		.rstn                (rstn),
		.grant               (grant),
		.grant_flow          (grant_flow),
		.head_desc           (head_desc),
		.head_empty          (head_empty),
		.cur_flow            (cur_flow),
		.pop                 (pop),
		.arb_idle            (arb_idle),
		.b_raddr             (b_raddr),
		.s_rvalid            (s_rvalid),
		.freed_pointer       (freed_pointer),
		.freed_pointer_valid (freed_pointer_valid)
	);

endmodule

/* tb/buffer_read_sched_tb.sv */
module buffer_read_sched_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import buf_addr_pkg::*;
	import flow_sched_pkg::*;

	logic clk;
	logic rstn;
	ptr_desc_t used_pointer;
	logic used_pointer_valid;
	flow_id_t used_pointer_flow;
	buf_addr_t b_raddr;
	logic s_rvalid;
	seg_addr_t freed_pointer;
	logic freed_pointer_valid;

	// W and D commands from the trace in file order
	byte cmd_kind [$];
	int cmd_a [$];
	int cmd_b [$];
	int cmd_c [$];
	int cmd_d [$];
	// one expected word or freed pointer per entry
	bit exp_is_free [$];
	buf_addr_t exp_val [$];
	// cycles since the last strobe while items are still owed
	int quiet_cycles;

	buffer_read_sched buffer_read_sched_i (
		.clk                 (clk),
		.rstn                (rstn),
		.used_pointer        (used_pointer),
		.used_pointer_valid  (used_pointer_valid),
		.used_pointer_flow   (used_pointer_flow),
		.b_raddr             (b_raddr),
		.s_rvalid            (s_rvalid),
		.freed_pointer       (freed_pointer),
		.freed_pointer_valid (freed_pointer_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_raddr(input buf_addr_t got, input buf_addr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: b_raddr %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic check_freed(input seg_addr_t got, input seg_addr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: freed_pointer %h, expected %h",
				$time, got, exp));
		end
	endtask

	// E lines expand into their words and one freed pointer
	task automatic load_trace;
		int fd;
		int n;
		int a;
		int b;
		int c;
		int d;
		string line;
		string rest;
		byte kind;
		fd = $fopen("tb/sched_trace.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the trace file tb/sched_trace.txt");
		end
		while ($fgets(line, fd) != 0) begin
			kind = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			if (kind == "W") begin
				n = $sscanf(rest, "%h %h %h %h", a, b, c, d);
				if (n != 4) begin
					abort_run("malformed W line in the trace file");
				end
			end else if (kind == "D") begin
				n = $sscanf(rest, "%d", a);
				if (n != 1) begin
					abort_run("malformed D line in the trace file");
				end
			end else if (kind == "E") begin
				n = $sscanf(rest, "%h %h", a, b);
				if (n != 2) begin
					abort_run("malformed E line in the trace file");
				end
				// segment address followed by each index up to the last
				for (int i = 0; i <= b; i++) begin
					exp_is_free.push_back(1'b0);
					exp_val.push_back({seg_addr_t'(a), word_idx_t'(i)});
				end
				exp_is_free.push_back(1'b1);
				exp_val.push_back(buf_addr_t'(seg_addr_t'(a)));
			end
			// comments and blank lines carry no command
			if (kind == "W" || kind == "D") begin
				cmd_kind.push_back(kind);
				cmd_a.push_back(a);
				cmd_b.push_back(b);
				cmd_c.push_back(c);
				cmd_d.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// one-cycle write strobe of a {final, last index, segment} descriptor
	task automatic drive_write(input flow_id_t flow, input logic fin, input word_idx_t last,
		input seg_addr_t seg);
		@(negedge clk);
		used_pointer = {fin, last, seg};
		used_pointer_flow = flow;
		used_pointer_valid = 1'b1;
		@(negedge clk);
		used_pointer_valid = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// wait until every expected item has been seen
	task automatic drain_expected;
		int waited;
		waited = 0;
		while (exp_val.size() != 0 && waited < 2000) begin
			@(posedge clk);
			waited++;
		end
	endtask

	// compare every read word and freed pointer in trace order
	always @(negedge clk) begin : monitor
		bit is_free;
		buf_addr_t val;
		if (s_rvalid || freed_pointer_valid) begin
			quiet_cycles = 0;
			if (exp_val.size() == 0) begin
				abort_run("strobe seen after the last expected segment");
			end else begin
				is_free = exp_is_free.pop_front();
				val = exp_val.pop_front();
				if (s_rvalid && is_free) begin
					abort_run("read word seen where a freed pointer was expected");
				end else if (s_rvalid) begin
					check_raddr(b_raddr, val);
				end else if (!is_free) begin
					abort_run("freed pointer seen before the segment's last word");
				end else begin
					check_freed(freed_pointer, seg_addr_t'(val));
				end
			end
		end else if (exp_val.size() != 0) begin
			quiet_cycles++;
			if (quiet_cycles > 2000) begin
				abort_run("timeout, no strobe for 2000 cycles while segments are owed");
			end
		end
	end

	initial begin
		rstn = 1'b0;
		used_pointer = '0;
		used_pointer_valid = 1'b0;
		used_pointer_flow = '0;
		quiet_cycles = 0;
		load_trace();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		for (int k = 0; k < cmd_kind.size(); k++) begin
			if (cmd_kind[k] == "W") begin
				drive_write(flow_id_t'(cmd_a[k]), cmd_b[k][0], word_idx_t'(cmd_c[k]),
					seg_addr_t'(cmd_d[k]));
			end else begin
				wait_cycles(cmd_a[k]);
			end
		end
		drain_expected();
		if (exp_val.size() != 0) begin
			abort_run("timeout, expected segments were never streamed");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* tb/sched_trace.txt */
# W flow final last_idx seg_addr : one descriptor write, fields in hex
# D cycles : driver waits this many cycles, decimal
# E seg_addr last_idx : next segment expected on the read side, hex
W 3 1 5 05
D 40
E 05 5
W 0 0 f 10
W 0 0 f 11
W 0 0 f 12
W 0 1 f 13
D 12
E 10 f
E 11 f
E 12 f
E 13 f
W 1 1 2 18
W 2 1 2 19
W 3 1 2 1a
W 4 1 2 1b
W 5 1 2 1c
W 6 1 2 1d
W 7 1 2 1e
W 0 1 1 1f
D 200
E 18 2
E 19 2
E 1a 2
E 1b 2
E 1c 2
E 1d 2
E 1e 2
E 1f 1
W 5 0 3 20
D 10
W 6 1 1 21
D 60
W 5 1 2 22
D 40
E 20 3
E 22 2
E 21 1
W 2 1 0 30
D 15
W 7 1 f 31
D 40
D 50
E 30 0
E 31 f

/* build.f */
hw/buf_addr_pkg.sv
hw/flow_sched_pkg.sv
hw/seg_ptr_fifo.sv
hw/flow_ptr_queues.sv
hw/rr_flow_arbiter.sv
hw/segment_reader.sv
hw/buffer_read_sched.sv
tb/buffer_read_sched_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module buffer_read_sched_tb \
	-Mdir obj_dir -o sim_tb
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
else
	exit 1
fi
